// File: hdl/mon_defs.svh
// --------------------
// Table depth and field widths of the AXI read monitor
// MON_CNT_W must hold the value MON_MAX_TRANS
// --------------------

`ifndef MON_DEFS_SVH
`define MON_DEFS_SVH

// Number of outstanding transactions tracked
`define MON_MAX_TRANS 16

// Slot index width
`define MON_IDX_W $clog2(`MON_MAX_TRANS)

// AXI ID width
`define MON_ID_W 8

// AXI address width
`define MON_ADDR_W 32

// AXI burst length, beat counters use one bit more
`define MON_LEN_W 8

// Active transaction count width
`define MON_CNT_W 8

`endif

// File: hdl/mon_pkg.sv
// --------------------
// Types shared by the AXI read monitor blocks
// --------------------

`default_nettype none

`include "mon_defs.svh"

package mon_pkg;

        // Transaction lifecycle
        typedef enum logic [2:0] {
                trans_idle       = 3'd0,
                trans_addr_phase = 3'd1,
                trans_data_phase = 3'd2,
                trans_complete   = 3'd3,
                trans_error      = 3'd4,
                trans_orphaned   = 3'd5
        } trans_state_t;

        // Codes handed to the reporter
        typedef enum logic [3:0] {
                evt_none        = 4'h0,
                evt_resp_slverr = 4'h1,
                evt_resp_decerr = 4'h2,
                evt_data_orphan = 4'h3
        } evt_code_t;

        // AR channel fields
        typedef struct packed {
                logic [`MON_ID_W-1:0]   id;
                logic [`MON_ADDR_W-1:0] addr;
                logic [`MON_LEN_W-1:0]  len;
                logic [2:0]             size;
                logic [1:0]             burst;
        } ar_beat_t;

        // R channel fields, the data payload is not tracked
        typedef struct packed {
                logic [`MON_ID_W-1:0] id;
                logic                 last;
                logic [1:0]           resp;
        } r_beat_t;

        typedef struct packed {
                logic                   valid;
                trans_state_t           state;
                logic [`MON_ID_W-1:0]   id;
                logic [`MON_ADDR_W-1:0] addr;
                logic [`MON_LEN_W-1:0]  len;
                logic [2:0]             size;
                logic [1:0]             burst;
                logic                   cmd_received;
                logic                   data_started;
                logic                   data_completed;
                logic [`MON_LEN_W:0]    beat_count;
                logic [`MON_LEN_W:0]    expected_beats;
                evt_code_t              evt_code;
                logic                   event_reported;
        } trans_entry_t;

        typedef trans_entry_t [`MON_MAX_TRANS-1:0] trans_table_t;

endpackage

`default_nettype wire

// File: hdl/trans_lookup.sv
// --------------------
// Combinational searches over the registered table
// Every search returns the lowest qualifying slot
// --------------------

`default_nettype none

`include "mon_defs.svh"

module trans_lookup
        import mon_pkg::*;
(
        input  trans_table_t                trans_table,
        input  ar_beat_t                    ar,
        input  r_beat_t                     r,

        output logic                        ar_match_valid,
        output logic [`MON_IDX_W-1:0]       ar_match_idx,
        output logic                        r_match_valid,
        output logic [`MON_IDX_W-1:0]       r_match_idx,
        output logic                        free_valid,
        output logic [`MON_IDX_W-1:0]       free_idx,
        output logic [`MON_MAX_TRANS-1:0]   cleanup
);

        // --------------------
        // ID and free slot search
        // --------------------

        // Walking down from the top leaves the lowest hit in place
        always_comb begin
                ar_match_valid = 1'b0;
                ar_match_idx   = '0;
                r_match_valid  = 1'b0;
                r_match_idx    = '0;
                free_valid     = 1'b0;
                free_idx       = '0;

                for (int i = `MON_MAX_TRANS - 1; i >= 0; i--) begin
                        if (trans_table[i].valid && trans_table[i].id == ar.id) begin
                                ar_match_valid = 1'b1;
                                ar_match_idx   = i[`MON_IDX_W-1:0];
                        end
                        if (trans_table[i].valid && trans_table[i].id == r.id) begin
                                r_match_valid = 1'b1;
                                r_match_idx   = i[`MON_IDX_W-1:0];
                        end
                        if (!trans_table[i].valid) begin
                                free_valid = 1'b1;
                                free_idx   = i[`MON_IDX_W-1:0];
                        end
                end
        end

        // --------------------
        // Retirement
        // --------------------

        // Finished entries wait for the reporter before they are freed
        always_comb begin
                for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                        cleanup[i] = trans_table[i].valid &&
                                     trans_table[i].event_reported &&
                                     (trans_table[i].state inside {trans_complete,
                                                                   trans_error,
                                                                   trans_orphaned});
                end
        end

endmodule

`default_nettype wire

// File: hdl/trans_table.sv
// --------------------
// Registered table, applies the results of trans_lookup
// Commands and orphan beats that find no free slot are dropped
// Allocation of a command beats orphan creation for the same free slot
// --------------------

`default_nettype none

`include "mon_defs.svh"

module trans_table
        import mon_pkg::*;
(
        input  logic                        aclk,
        input  logic                        rst_n,

        input  logic                        ar_valid,
        input  logic                        ar_ready,
        input  ar_beat_t                    ar,

        input  logic                        r_valid,
        input  logic                        r_ready,
        input  r_beat_t                     r,

        input  logic [`MON_MAX_TRANS-1:0]   event_reported,

        input  logic                        ar_match_valid,
        input  logic [`MON_IDX_W-1:0]       ar_match_idx,
        input  logic                        r_match_valid,
        input  logic [`MON_IDX_W-1:0]       r_match_idx,
        input  logic                        free_valid,
        input  logic [`MON_IDX_W-1:0]       free_idx,
        input  logic [`MON_MAX_TRANS-1:0]   cleanup,

        output trans_table_t                trans_table,
        output logic [`MON_CNT_W-1:0]       active_count
);

        logic                       ar_alloc;
        logic                       ar_accept;
        logic                       r_fire;
        logic                       r_update;
        logic                       r_orphan;
        logic [`MON_CNT_W-1:0]      freed_count;
        logic [`MON_MAX_TRANS-1:0]  valid_mask;
        trans_entry_t               ar_entry;
        trans_entry_t               orphan_entry;

        // A new ID takes a slot as soon as valid is seen, before the handshake
        assign ar_alloc  = ar_valid && !ar_match_valid && free_valid;
        assign ar_accept = ar_valid && ar_ready && ar_match_valid;

        assign r_fire   = r_valid && r_ready;
        assign r_update = r_fire && r_match_valid;
        assign r_orphan = r_fire && !r_match_valid && free_valid && !ar_alloc;

        assign freed_count = `MON_CNT_W'($countones(cleanup));

        always_comb begin
                for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                        valid_mask[i] = trans_table[i].valid;
                end
        end

        // --------------------
        // New entries
        // --------------------

        always_comb begin
                ar_entry                = '0;
                ar_entry.valid          = 1'b1;
                ar_entry.state          = trans_addr_phase;
                ar_entry.id             = ar.id;
                ar_entry.addr           = ar.addr;
                ar_entry.len            = ar.len;
                ar_entry.size           = ar.size;
                ar_entry.burst          = ar.burst;
                ar_entry.cmd_received   = ar_ready;
                ar_entry.expected_beats = {1'b0, ar.len} + 1'b1;
                ar_entry.evt_code       = evt_none;
        end

        // Data with no command behind it
        always_comb begin
                orphan_entry                = '0;
                orphan_entry.valid          = 1'b1;
                orphan_entry.state          = trans_orphaned;
                orphan_entry.id             = r.id;
                orphan_entry.data_started   = 1'b1;
                orphan_entry.data_completed = r.last;
                orphan_entry.beat_count     = 1;
                orphan_entry.evt_code       = evt_data_orphan;
        end

        // --------------------
        // Table update
        // --------------------

        always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                        trans_table  <= '0;
                        active_count <= '0;
                end else begin
                        // Reporter feedback on live entries
                        for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                                if (event_reported[i] && trans_table[i].valid) begin
                                        trans_table[i].event_reported <= 1'b1;
                                end
                        end

                        if (ar_alloc) begin
                                trans_table[free_idx] <= ar_entry;
                        end

                        // Late AR handshake on an existing entry
                        if (ar_accept) begin
                                trans_table[ar_match_idx].cmd_received <= 1'b1;
                        end

                        if (r_update) begin
                                trans_table[r_match_idx].data_started <= 1'b1;
                                trans_table[r_match_idx].beat_count <=
                                        trans_table[r_match_idx].beat_count + 1'b1;
                                if (r.last) begin
                                        trans_table[r_match_idx].data_completed <= 1'b1;
                                end

                                // Error response overrides completion
                                if (r.resp[1]) begin
                                        trans_table[r_match_idx].state <= trans_error;
                                        trans_table[r_match_idx].evt_code <=
                                                r.resp[0] ? evt_resp_decerr : evt_resp_slverr;
                                end else if (r.last) begin
                                        trans_table[r_match_idx].state <= trans_complete;
                                end else begin
                                        trans_table[r_match_idx].state <= trans_data_phase;
                                end
                        end

                        if (r_orphan) begin
                                trans_table[free_idx] <= orphan_entry;
                        end

                        for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                                if (cleanup[i]) begin
                                        trans_table[i].valid <= 1'b0;
                                        trans_table[i].state <= trans_idle;
                                end
                        end

                        // Allocation and retirement in one cycle both count
                        active_count <= active_count
                                        + {{(`MON_CNT_W-1){1'b0}}, ar_alloc || r_orphan}
                                        - freed_count;
                end
        end

        // --------------------
        // Assertions
        // --------------------

        a_count_bound: assert property (@(posedge aclk) disable iff (!rst_n)
                active_count <= `MON_MAX_TRANS);

        // Counter follows the live slots through every allocation and free
        a_count_live: assert property (@(posedge aclk) disable iff (!rst_n)
                active_count == `MON_CNT_W'($countones(valid_mask)));

endmodule

`default_nettype wire

// File: hdl/state_change_detect.sv
// --------------------
// One cycle flag per slot, one edge after its state moved
// Allocation and freeing are not flagged
// --------------------

`default_nettype none

`include "mon_defs.svh"

module state_change_detect
        import mon_pkg::*;
(
        input  logic                        aclk,
        input  logic                        rst_n,
        input  trans_table_t                trans_table,
        output logic [`MON_MAX_TRANS-1:0]   state_change
);

        logic [`MON_MAX_TRANS-1:0]          prev_valid;
        trans_state_t [`MON_MAX_TRANS-1:0]  prev_state;

        always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                        prev_valid   <= '0;
                        state_change <= '0;
                        for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                                prev_state[i] <= trans_idle;
                        end
                end else begin
                        for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                                prev_valid[i] <= trans_table[i].valid;
                                prev_state[i] <= trans_table[i].state;

                                // Slot must be live on both sides of the change
                                state_change[i] <= trans_table[i].valid && prev_valid[i] &&
                                                   (trans_table[i].state != prev_state[i]);
                        end
                end
        end

endmodule

`default_nettype wire

// File: hdl/axi_rd_monitor.sv
// --------------------
// AXI4 read port monitor, observes AR and R and never drives ready
// event_reported is a per-slot level from the reporter
// --------------------

`default_nettype none

`include "mon_defs.svh"

module axi_rd_monitor
        import mon_pkg::*;
(
        input  logic                        aclk,
        input  logic                        rst_n,

        // AR channel
        input  logic                        ar_valid,
        input  logic                        ar_ready,
        input  logic [`MON_ID_W-1:0]        ar_id,
        input  logic [`MON_ADDR_W-1:0]      ar_addr,
        input  logic [`MON_LEN_W-1:0]       ar_len,
        input  logic [2:0]                  ar_size,
        input  logic [1:0]                  ar_burst,

        // R channel
        input  logic                        r_valid,
        input  logic                        r_ready,
        input  logic [`MON_ID_W-1:0]        r_id,
        input  logic                        r_last,
        input  logic [1:0]                  r_resp,

        input  logic [`MON_MAX_TRANS-1:0]   event_reported,

        output trans_table_t                trans_table,
        output logic [`MON_CNT_W-1:0]       active_count,
        output logic [`MON_MAX_TRANS-1:0]   state_change
);

        ar_beat_t                   ar;
        r_beat_t                    r;
        logic                       ar_match_valid;
        logic [`MON_IDX_W-1:0]      ar_match_idx;
        logic                       r_match_valid;
        logic [`MON_IDX_W-1:0]      r_match_idx;
        logic                       free_valid;
        logic [`MON_IDX_W-1:0]      free_idx;
        logic [`MON_MAX_TRANS-1:0]  cleanup;

        assign ar = '{id: ar_id, addr: ar_addr, len: ar_len, size: ar_size, burst: ar_burst};
        assign r  = '{id: r_id, last: r_last, resp: r_resp};

        trans_lookup u_lookup (
                .trans_table    (trans_table),
                .ar             (ar),
                .r              (r),
                .ar_match_valid (ar_match_valid),
                .ar_match_idx   (ar_match_idx),
                .r_match_valid  (r_match_valid),
                .r_match_idx    (r_match_idx),
                .free_valid     (free_valid),
                .free_idx       (free_idx),
                .cleanup        (cleanup)
        );

        trans_table u_table (
                .aclk           (aclk),
                .rst_n          (rst_n),
                .ar_valid       (ar_valid),
                .ar_ready       (ar_ready),
                .ar             (ar),
                .r_valid        (r_valid),
                .r_ready        (r_ready),
                .r              (r),
                .event_reported (event_reported),
                .ar_match_valid (ar_match_valid),
                .ar_match_idx   (ar_match_idx),
                .r_match_valid  (r_match_valid),
                .r_match_idx    (r_match_idx),
                .free_valid     (free_valid),
                .free_idx       (free_idx),
                .cleanup        (cleanup),
                .trans_table    (trans_table),
                .active_count   (active_count)
        );

        state_change_detect u_change (
                .aclk           (aclk),
                .rst_n          (rst_n),
                .trans_table    (trans_table),
                .state_change   (state_change)
        );

endmodule

`default_nettype wire

// File: verif/tb_axi_rd_monitor.sv
// --------------------
// Directed testbench for the AXI read monitor
// Inputs change and outputs are sampled on the falling edge
// --------------------

`default_nettype none

`include "mon_defs.svh"

module tb_axi_rd_monitor
        import mon_pkg::*;
();

        logic                       aclk;
        logic                       rst_n;
        logic                       ar_valid;
        logic                       ar_ready;
        logic [`MON_ID_W-1:0]       ar_id;
        logic [`MON_ADDR_W-1:0]     ar_addr;
        logic [`MON_LEN_W-1:0]      ar_len;
        logic [2:0]                 ar_size;
        logic [1:0]                 ar_burst;
        logic                       r_valid;
        logic                       r_ready;
        logic [`MON_ID_W-1:0]       r_id;
        logic                       r_last;
        logic [1:0]                 r_resp;
        logic [`MON_MAX_TRANS-1:0]  event_reported;
        trans_table_t               mon_table;
        logic [`MON_CNT_W-1:0]      active_count;
        logic [`MON_MAX_TRANS-1:0]  state_change;

        // Expected occupancy, built from the allocation rules
        logic [`MON_MAX_TRANS-1:0]  exp_valid;
        int                         exp_count;
        logic [255:0]               id_used;
        logic [`MON_ID_W-1:0]       id_a;
        logic [`MON_ID_W-1:0]       id_b;
        logic [`MON_LEN_W-1:0]      len_a;
        int                         slot_a;
        int                         slot_b;

        axi_rd_monitor dut (
                .aclk           (aclk),
                .rst_n          (rst_n),
                .ar_valid       (ar_valid),
                .ar_ready       (ar_ready),
                .ar_id          (ar_id),
                .ar_addr        (ar_addr),
                .ar_len         (ar_len),
                .ar_size        (ar_size),
                .ar_burst       (ar_burst),
                .r_valid        (r_valid),
                .r_ready        (r_ready),
                .r_id           (r_id),
                .r_last         (r_last),
                .r_resp         (r_resp),
                .event_reported (event_reported),
                .trans_table    (mon_table),
                .active_count   (active_count),
                .state_change   (state_change)
        );

        initial begin
                aclk = 1'b0;
                forever #50 aclk = ~aclk;
        end

        // --------------------
        // Helpers
        // --------------------

        task automatic report_failure(input string what);
                $display("%s", what);
                $display("Simulation failed");
                $fatal(1);
        endtask

        task automatic check_val(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
                assert (got === exp) else begin
                        report_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                                                 name, got, exp));
                end
        endtask

        function automatic string fld(input int s, input string f);
                return $sformatf("trans_table[%0d].%s", s, f);
        endfunction

        // Random ID that no earlier test has used
        function automatic logic [`MON_ID_W-1:0] new_id();
                logic [`MON_ID_W-1:0] id;
                id = `MON_ID_W'($urandom);
                while (id_used[id]) begin
                        id = id + 1'b1;
                end
                id_used[id] = 1'b1;
                return id;
        endfunction

        function automatic int lowest_free();
                for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                        if (!exp_valid[i]) begin
                                return i;
                        end
                end
                return -1;
        endfunction

        function automatic logic [`MON_MAX_TRANS-1:0] live_mask();
                logic [`MON_MAX_TRANS-1:0] m;
                for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                        m[i] = mon_table[i].valid;
                end
                return m;
        endfunction

        task automatic step();
                @(negedge aclk);
        endtask

        task automatic drive_ar(input logic [`MON_ID_W-1:0] id,
                                input logic [`MON_LEN_W-1:0] len, input logic ready);
                ar_valid = 1'b1;
                ar_ready = ready;
                ar_id    = id;
                ar_addr  = $urandom;
                ar_len   = len;
                ar_size  = 3'd2;
                ar_burst = 2'b01;
        endtask

        task automatic drive_r(input logic [`MON_ID_W-1:0] id, input logic last,
                               input logic [1:0] resp);
                r_valid = 1'b1;
                r_ready = 1'b1;
                r_id    = id;
                r_last  = last;
                r_resp  = resp;
        endtask

        task automatic check_head(input int s, input logic [`MON_ID_W-1:0] id,
                                  input trans_state_t st);
                check_val(fld(s, "valid"), mon_table[s].valid, 1'b1);
                check_val(fld(s, "state"), mon_table[s].state, st);
                check_val(fld(s, "id"), mon_table[s].id, id);
        endtask

        // --------------------
        // Tests
        // --------------------

        task automatic test_allocation();
                id_a   = new_id();
                len_a  = `MON_LEN_W'(1 + $urandom % 4);
                slot_a = lowest_free();
                drive_ar(id_a, len_a, 1'b1);
                step();
                ar_valid = 1'b0;
                exp_valid[slot_a] = 1'b1;
                exp_count++;
                check_head(slot_a, id_a, trans_addr_phase);
                check_val(fld(slot_a, "addr"), mon_table[slot_a].addr, ar_addr);
                check_val(fld(slot_a, "len"), mon_table[slot_a].len, len_a);
                check_val(fld(slot_a, "size"), mon_table[slot_a].size, 3'd2);
                check_val(fld(slot_a, "burst"), mon_table[slot_a].burst, 2'b01);
                check_val(fld(slot_a, "cmd_received"), mon_table[slot_a].cmd_received, 1'b1);
                check_val(fld(slot_a, "expected_beats"), mon_table[slot_a].expected_beats,
                          int'(len_a) + 1);
                check_val("active_count", active_count, exp_count);

                // Command held off by ar_ready
                id_b   = new_id();
                slot_b = lowest_free();
                drive_ar(id_b, 8'd0, 1'b0);
                step();
                exp_valid[slot_b] = 1'b1;
                exp_count++;
                check_head(slot_b, id_b, trans_addr_phase);
                check_val(fld(slot_b, "cmd_received"), mon_table[slot_b].cmd_received, 1'b0);
                check_val("active_count", active_count, exp_count);
                ar_ready = 1'b1;
                step();
                ar_valid = 1'b0;
                ar_ready = 1'b0;
                check_val(fld(slot_b, "cmd_received"), mon_table[slot_b].cmd_received, 1'b1);
        endtask

        task automatic test_burst();
                trans_state_t prev;
                trans_state_t next;
                prev = trans_addr_phase;
                for (int b = 0; b <= int'(len_a); b++) begin
                        next = (b == int'(len_a)) ? trans_complete : trans_data_phase;
                        drive_r(id_a, b == int'(len_a), 2'b00);
                        step();
                        r_valid = 1'b0;
                        check_head(slot_a, id_a, next);
                        check_val(fld(slot_a, "beat_count"), mon_table[slot_a].beat_count, b + 1);
                        step();
                        check_val("state_change", state_change[slot_a], prev != next);
                        step();
                        check_val("state_change", state_change[slot_a], 1'b0);
                        prev = next;
                end
                check_val(fld(slot_a, "data_started"), mon_table[slot_a].data_started, 1'b1);
                check_val(fld(slot_a, "data_completed"), mon_table[slot_a].data_completed, 1'b1);
        endtask

        task automatic test_errors();
                logic [`MON_ID_W-1:0] id_c;
                int                   slot_c;
                drive_r(id_b, 1'b0, 2'b10);
                step();
                r_valid = 1'b0;
                check_head(slot_b, id_b, trans_error);
                check_val(fld(slot_b, "evt_code"), mon_table[slot_b].evt_code, evt_resp_slverr);

                id_c   = new_id();
                slot_c = lowest_free();
                drive_ar(id_c, 8'd3, 1'b1);
                step();
                ar_valid = 1'b0;
                exp_valid[slot_c] = 1'b1;
                exp_count++;
                drive_r(id_c, 1'b0, 2'b11);
                step();
                r_valid = 1'b0;
                check_head(slot_c, id_c, trans_error);
                check_val(fld(slot_c, "evt_code"), mon_table[slot_c].evt_code, evt_resp_decerr);
                check_val("active_count", active_count, exp_count);
        endtask

        task automatic test_orphan();
                logic [`MON_ID_W-1:0] id_d;
                int                   slot_d;
                logic                 last_bit;
                id_d     = new_id();
                slot_d   = lowest_free();
                last_bit = 1'($urandom);
                drive_r(id_d, last_bit, 2'b00);
                step();
                r_valid = 1'b0;
                exp_valid[slot_d] = 1'b1;
                exp_count++;
                check_head(slot_d, id_d, trans_orphaned);
                check_val(fld(slot_d, "evt_code"), mon_table[slot_d].evt_code, evt_data_orphan);
                check_val(fld(slot_d, "beat_count"), mon_table[slot_d].beat_count, 1);
                check_val(fld(slot_d, "data_completed"), mon_table[slot_d].data_completed,
                          last_bit);
                check_val("active_count", active_count, exp_count);
        endtask

        task automatic test_cleanup();
                logic [`MON_MAX_TRANS-1:0] done_mask;
                int                        cycles;
                done_mask      = exp_valid;
                event_reported = done_mask;
                step();
                event_reported = '0;
                cycles         = 1;
                for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                        if (done_mask[i]) begin
                                check_val(fld(i, "event_reported"),
                                          mon_table[i].event_reported, 1'b1);
                                check_val(fld(i, "valid"), mon_table[i].valid, 1'b1);
                        end
                end
                while ((live_mask() & done_mask) != '0) begin
                        if (cycles >= 10) begin
                                report_failure("reported entries were never freed");
                        end else begin
                                step();
                                cycles++;
                        end
                end
                check_val("cleanup edges", cycles, 2);
                exp_valid = exp_valid & ~done_mask;
                exp_count = exp_count - $countones(done_mask);
                check_val("active_count", active_count, exp_count);
        endtask

        task automatic test_full_table();
                logic [`MON_ID_W-1:0] fill_id;
                int                   s;
                trans_table_t         snap;
                while (lowest_free() >= 0) begin
                        fill_id = new_id();
                        s       = lowest_free();
                        drive_ar(fill_id, 8'd0, 1'b1);
                        step();
                        exp_valid[s] = 1'b1;
                        exp_count++;
                        check_head(s, fill_id, trans_addr_phase);
                end
                ar_valid = 1'b0;
                check_val("active_count", active_count, `MON_MAX_TRANS);

                // One more new ID finds no slot
                snap = mon_table;
                drive_ar(new_id(), 8'd0, 1'b1);
                step();
                ar_valid = 1'b0;
                step();
                for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                        check_val(fld(i, "entry"), mon_table[i], snap[i]);
                end
                check_val("active_count", active_count, `MON_MAX_TRANS);
        endtask

        // Hard limit on the run length
        initial begin
                repeat (5000) @(posedge aclk);
                report_failure("simulation timed out");
        end

        initial begin
                void'($urandom(32'h553d_6e8c));
                rst_n          = 1'b0;
                ar_valid       = 1'b0;
                ar_ready       = 1'b0;
                ar_id          = '0;
                ar_addr        = '0;
                ar_len         = '0;
                ar_size        = '0;
                ar_burst       = '0;
                r_valid        = 1'b0;
                r_ready        = 1'b0;
                r_id           = '0;
                r_last         = 1'b0;
                r_resp         = '0;
                event_reported = '0;
                exp_valid      = '0;
                exp_count      = 0;
                id_used        = '0;
                repeat (10) @(negedge aclk);
                check_val("active_count", active_count, 0);
                check_val("state_change", state_change, 0);
                check_val("valid bits", live_mask(), 0);
                rst_n = 1'b1;
                step();

                test_allocation();
                test_burst();
                test_errors();
                test_orphan();
                test_cleanup();
                test_full_table();

                $display("Simulation passed");
                $finish;
        end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/mon_pkg.sv
hdl/trans_lookup.sv
hdl/trans_table.sv
hdl/state_change_detect.sv
hdl/axi_rd_monitor.sv
verif/tb_axi_rd_monitor.sv

// File: run.sh
#!/bin/sh
# Build and run the AXI read monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module tb_axi_rd_monitor -o sim_tb > build.log 2>&1 \
        || { cat build.log; echo "build error"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

! grep -q "Simulation failed" sim.log && grep -q "Simulation passed" sim.log \
        && echo "PASS" || { echo "FAIL"; exit 1; }
